// File: src/gbar_consts.svh
/*
 * Sizing constants for the global barrier block.
 * Include this header in any file that needs core or barrier widths.
 * Change GBAR_NUM_CORES or GBAR_NUM_BARRIERS here and the derived
 * widths follow on their own.
 */
`ifndef GBAR_CONSTS_SVH
`define GBAR_CONSTS_SVH

// Number of cores in the cluster that can join a global barrier
`define GBAR_NUM_CORES 4

// Number of independent barrier ids tracked by the unit
`define GBAR_NUM_BARRIERS 4

// Width of a core id
`define GBAR_CORE_W $clog2(`GBAR_NUM_CORES)

// Width of a barrier id
`define GBAR_BAR_W $clog2(`GBAR_NUM_BARRIERS)

// Width of a participant count, which must hold the full core count
`define GBAR_CNT_W $clog2(`GBAR_NUM_CORES + 1)

`endif

// File: src/gbar_pkg.sv
/*
 * Types shared by the global barrier block.
 * Holds the barrier opcode and the instruction, request and response
 * structs that travel between decode, arbiter, unit and release stage.
 * Compile this package before any module of the block.
 */
`include "gbar_consts.svh"

package gbar_pkg;

    // Barrier opcodes as seen by the per-core decoder
    // OP_LOCAL stays inside a core and is ignored by this block
    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_GLOBAL = 2'd1,
        OP_LOCAL  = 2'd2
    } gbar_op_t;

    // Barrier instruction issued by a core
    // The count field is the number of cores taking part
    typedef struct packed {
        gbar_op_t                op;
        logic [`GBAR_BAR_W-1:0]  bar_id;
        logic [`GBAR_CNT_W-1:0]  count;
    } gbar_instr_t;

    // Arrival request sent to the barrier unit
    // size_m1 is the participant count minus one, so it can be compared
    // straight against the number of cores already waiting
    typedef struct packed {
        logic [`GBAR_BAR_W-1:0]  bar_id;
        logic [`GBAR_CORE_W-1:0] core_id;
        logic [`GBAR_CNT_W-1:0]  size_m1;
    } gbar_req_t;

    // Release response, names the barrier that just completed
    typedef struct packed {
        logic [`GBAR_BAR_W-1:0]  bar_id;
    } gbar_rsp_t;

endpackage

// File: src/gbar_decode.sv
/*
 * Per-core decoder for barrier instructions.
 * A legal global barrier becomes a registered arrival request stamped
 * with this core's id. A global barrier with an illegal participant
 * count raises a one-cycle error pulse instead. Other opcodes are dropped.
 * One instance sits in front of each core.
 */
`timescale 1ns/1ps
`include "gbar_consts.svh"

module gbar_decode #(
    parameter int CORE_ID = 0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  gbar_pkg::gbar_instr_t instr,
    output logic                dec_valid,
    output gbar_pkg::gbar_req_t dec_req,
    output logic                err
);
    import gbar_pkg::*;

    // Core id as it appears in the request
    localparam logic [`GBAR_CORE_W-1:0] CORE_ID_BITS = CORE_ID[`GBAR_CORE_W-1:0];

    logic is_global;
    logic count_ok;

    // Local barriers never leave the core, so only OP_GLOBAL matters here
    assign is_global = instr_valid && (instr.op == OP_GLOBAL);

    // A barrier needs at least one participant and no more than the cluster
    assign count_ok = (instr.count != '0) && (instr.count <= `GBAR_NUM_CORES);

    // Strobes for request and error, each one cycle after the instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            err       <= 1'b0;
        end else begin
            dec_valid <= is_global && count_ok;
            err       <= is_global && !count_ok;
        end
    end

    // Request payload, only meaningful while dec_valid is high
    always_ff @(posedge clk) begin
        if (is_global) begin
            dec_req.bar_id  <= instr.bar_id;
            dec_req.core_id <= CORE_ID_BITS;
            // Unit compares against the cores already waiting, hence minus one
            dec_req.size_m1 <= instr.count - 1'b1;
        end
    end

endmodule

// File: src/gbar_req_arbiter.sv
/*
 * Serializer between the per-core decoders and the barrier unit.
 * Each core has one pending slot. A request that arrives while another
 * core holds the grant waits in its slot. One request per cycle goes to
 * the unit, picked round-robin starting after the last granted core.
 * An uncontended request passes through in a single cycle.
 */
`timescale 1ns/1ps
`include "gbar_consts.svh"

module gbar_req_arbiter (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [`GBAR_NUM_CORES-1:0]                dec_valid,
    input  gbar_pkg::gbar_req_t [`GBAR_NUM_CORES-1:0] dec_req,
    output logic                                      req_valid,
    output gbar_pkg::gbar_req_t                       req
);
    import gbar_pkg::*;

    localparam int CORE_W    = `GBAR_CORE_W;
    localparam int LAST_CORE = `GBAR_NUM_CORES - 1;

    logic [`GBAR_NUM_CORES-1:0]      pending;
    gbar_req_t [`GBAR_NUM_CORES-1:0] slot;
    logic [`GBAR_NUM_CORES-1:0]      cand;
    logic [`GBAR_NUM_CORES-1:0]      grant_mask;
    logic [CORE_W-1:0]               last_grant;
    logic [CORE_W-1:0]               grant_idx;
    logic                            grant_found;
    gbar_req_t                       grant_req;

    // New arrivals compete in the same cycle so an idle path costs one cycle
    assign cand = pending | dec_valid;

    // Round-robin search starting one past the previous winner
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = last_grant;
        grant_mask  = '0;
        for (int i = 1; i <= `GBAR_NUM_CORES; i++) begin
            idx = (int'(last_grant) + i) % `GBAR_NUM_CORES;
            if (!grant_found && cand[idx]) begin
                grant_found     = 1'b1;
                grant_idx       = CORE_W'(idx);
                grant_mask[idx] = 1'b1;
            end
        end
    end

    // A waiting slot holds the request, a fresh arrival comes straight in
    assign grant_req = pending[grant_idx] ? slot[grant_idx] : dec_req[grant_idx];

    // Slot payloads are captured on every arrival
    always_ff @(posedge clk) begin
        for (int c = 0; c < `GBAR_NUM_CORES; c++) begin
            if (dec_valid[c]) begin
                slot[c] <= dec_req[c];
            end
        end
        if (grant_found) begin
            req <= grant_req;
        end
    end

    // Pending bits, grant pointer and the outgoing strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            pending    <= '0;
            last_grant <= LAST_CORE[CORE_W-1:0];
            req_valid  <= 1'b0;
        end else begin
            pending   <= cand & ~grant_mask;
            req_valid <= grant_found;
            if (grant_found) begin
                last_grant <= grant_idx;
            end
        end
    end

    // A stalled core cannot issue again, so its slot must be free on arrival
    for (genvar c = 0; c < `GBAR_NUM_CORES; c++) begin : g_slot_chk
        slot_free_on_write : assert property (
            @(posedge clk) disable iff (reset) dec_valid[c] |-> !pending[c]);
    end

endmodule

// File: src/gbar_unit.sv
/*
 * Global barrier unit.
 * Keeps one arrival mask per barrier id. On each arrival it counts the
 * cores already waiting on that id. If the arrival is the last participant
 * the mask is cleared and a release response goes out one cycle later,
 * otherwise the arriving core is added to the mask.
 * The unit accepts a request on every cycle.
 */
`timescale 1ns/1ps
`include "gbar_consts.svh"

module gbar_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  gbar_pkg::gbar_req_t req,
    output logic                rsp_valid,
    output gbar_pkg::gbar_rsp_t rsp
);
    localparam int CNT_W = `GBAR_CNT_W;

    // One bit per core for every barrier id
    logic [`GBAR_NUM_BARRIERS-1:0][`GBAR_NUM_CORES-1:0] masks;
    logic [`GBAR_NUM_CORES-1:0]                         cur_mask;
    logic [CNT_W-1:0]                                   arrived;
    logic                                               complete;

    assign cur_mask = masks[req.bar_id];

    // Population count of the cores already waiting on this id
    always_comb begin
        arrived = '0;
        for (int i = 0; i < `GBAR_NUM_CORES; i++) begin
            arrived = arrived + CNT_W'(cur_mask[i]);
        end
    end

    // The last participant is the one that finds size_m1 others waiting
    // A count of one therefore completes with an empty mask
    assign complete = req_valid && (arrived == req.size_m1);

    always_ff @(posedge clk) begin
        if (reset) begin
            masks     <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= complete;
            if (complete) begin
                // Free the id at once so it can be reused right away
                masks[req.bar_id] <= '0;
            end else if (req_valid) begin
                masks[req.bar_id][req.core_id] <= 1'b1;
            end
        end
    end

    // Response payload follows the completing request
    always_ff @(posedge clk) begin
        if (complete) begin
            rsp.bar_id <= req.bar_id;
        end
    end

    // A core stays stalled until release, so it cannot arrive twice
    no_double_arrival : assert property (
        @(posedge clk) disable iff (reset) req_valid |-> !cur_mask[req.core_id]);

endmodule

// File: src/gbar_release.sv
/*
 * Release stage of the global barrier block.
 * Remembers which barrier id each core waits on and holds that core's
 * stall from one cycle after its decoded request. When the unit reports a
 * completed id, every core waiting on it gets a one-cycle release pulse
 * and its stall drops in the same cycle.
 */
`timescale 1ns/1ps
`include "gbar_consts.svh"

module gbar_release (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [`GBAR_NUM_CORES-1:0]                dec_valid,
    input  gbar_pkg::gbar_req_t [`GBAR_NUM_CORES-1:0] dec_req,
    input  logic                                      rsp_valid,
    input  gbar_pkg::gbar_rsp_t                       rsp,
    output logic [`GBAR_NUM_CORES-1:0]                stall,
    output logic [`GBAR_NUM_CORES-1:0]                bar_release
);
    // Barrier id each core is waiting on, valid while its stall is high
    logic [`GBAR_BAR_W-1:0] wait_id [`GBAR_NUM_CORES];
    logic [`GBAR_NUM_CORES-1:0] hit;

    // Only cores already stalled can match, so a request decoded in the
    // same cycle as a response waits for the next completion of that id
    always_comb begin
        for (int c = 0; c < `GBAR_NUM_CORES; c++) begin
            hit[c] = rsp_valid && stall[c] && (wait_id[c] == rsp.bar_id);
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `GBAR_NUM_CORES; c++) begin
            if (dec_valid[c]) begin
                wait_id[c] <= dec_req[c].bar_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stall       <= '0;
            bar_release <= '0;
        end else begin
            bar_release <= hit;
            // Release clears the stall, a new request raises it
            stall       <= (stall & ~hit) | dec_valid;
        end
    end

    // Catches a core that issued another barrier while it was still stalled
    for (genvar c = 0; c < `GBAR_NUM_CORES; c++) begin : g_issue_chk
        no_issue_while_stalled : assert property (
            @(posedge clk) disable iff (reset) dec_valid[c] |-> !stall[c]);
    end

endmodule

// File: src/gbar_subsystem.sv
/*
 * Top level of the global barrier block.
 * Per-core decoders feed the request arbiter, which serializes arrivals
 * into the barrier unit. The release stage turns unit responses into
 * per-core release pulses and holds each waiting core's stall.
 * Only instances and wires live here.
 */
`timescale 1ns/1ps
`include "gbar_consts.svh"

module gbar_subsystem (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [`GBAR_NUM_CORES-1:0]                  instr_valid,
    input  gbar_pkg::gbar_instr_t [`GBAR_NUM_CORES-1:0] instr,
    output logic [`GBAR_NUM_CORES-1:0]                  err,
    output logic [`GBAR_NUM_CORES-1:0]                  stall,
    output logic [`GBAR_NUM_CORES-1:0]                  bar_release
);
    import gbar_pkg::*;

    // Decoded requests, one per core
    logic [`GBAR_NUM_CORES-1:0]      dec_valid;
    gbar_req_t [`GBAR_NUM_CORES-1:0] dec_req;

    // Serialized request into the unit
    logic      req_valid;
    gbar_req_t req;

    // Completion response out of the unit
    logic      rsp_valid;
    gbar_rsp_t rsp;

    // Decode stage, one decoder per core
    for (genvar c = 0; c < `GBAR_NUM_CORES; c++) begin : g_core
        gbar_decode #(
            .CORE_ID (c)
        ) decode0 (
            .clk         (clk),
            .reset       (reset),
            .instr_valid (instr_valid[c]),
            .instr       (instr[c]),
            .dec_valid   (dec_valid[c]),
            .dec_req     (dec_req[c]),
            .err         (err[c])
        );
    end

    // Execute stage, serialize and then track arrivals
    gbar_req_arbiter arbiter0 (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_req   (dec_req),
        .req_valid (req_valid),
        .req       (req)
    );

    gbar_unit unit0 (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // Result stage, the decoded requests start each core's wait here
    gbar_release release0 (
        .clk         (clk),
        .reset       (reset),
        .dec_valid   (dec_valid),
        .dec_req     (dec_req),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .stall       (stall),
        .bar_release (bar_release)
    );

endmodule

// File: verification/gbar_subsystem_tb.sv
/*
 * Testbench for the global barrier block.
 * Reads one step per line from verification/gbar_vectors.txt, drives the
 * per-core instruction ports on the falling clock edge and checks err,
 * stall and bar_release against the expected masks of every step.
 * Run the simulator from the project root so the vector path resolves.
 */
`timescale 1ns/1ps
`include "gbar_consts.svh"

module gbar_subsystem_tb;
    import gbar_pkg::*;

    localparam int NC           = `GBAR_NUM_CORES;
    localparam int VEC_WORDS    = 7;
    localparam int MAX_STEPS    = 64;
    localparam int REL_TIMEOUT  = 40;
    localparam int QUIET_CYCLES = 8;
    localparam int RESET_CYCLES = 16;

    logic                 clk;
    logic                 reset;
    logic [NC-1:0]        instr_valid;
    gbar_instr_t [NC-1:0] instr;
    logic [NC-1:0]        err;
    logic [NC-1:0]        stall;
    logic [NC-1:0]        bar_release;

    // Each step takes seven bytes for the valid mask, four instructions and two expected masks
    logic [7:0] vec [MAX_STEPS*VEC_WORDS];

    integer        seed;
    int            checks;
    int            errors;
    int            steps;
    // Cores that should be stalled according to the barrier rules
    logic [NC-1:0] waiting;
    logic [NC-1:0] err_seen;
    int            rel_cnt [NC];

    gbar_subsystem dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .err         (err),
        .stall       (stall),
        .bar_release (bar_release)
    );

    always #20 clk = ~clk;

    // Compare one value and report it right away when it differs
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Outputs settle after the rising edge, so they are read on the falling one
    task automatic sample_outputs();
        err_seen = err_seen | err;
        for (int c = 0; c < NC; c++) begin
            rel_cnt[c] = rel_cnt[c] + int'(bar_release[c]);
        end
    endtask

    task automatic idle_inputs();
        instr_valid = '0;
        instr       = '0;
    endtask

    // Cores that have seen at least one release pulse in this step
    function automatic logic [NC-1:0] released_mask();
        logic [NC-1:0] m;
        m = '0;
        for (int c = 0; c < NC; c++) begin
            m[c] = (rel_cnt[c] != 0);
        end
        return m;
    endfunction

    // Drive one step, wait for its releases and check what came back
    task automatic run_step(input int s);
        int            base;
        int            gap;
        int            wait_cycles;
        int            errors_before;
        logic [NC-1:0] vmask;
        logic [NC-1:0] exp_err;
        logic [NC-1:0] exp_rel;
        logic [NC-1:0] joined;
        logic [NC-1:0] rel_seen;
        gbar_instr_t   cur;
        base          = s * VEC_WORDS;
        vmask         = vec[base][NC-1:0];
        exp_err       = vec[base+5][NC-1:0];
        exp_rel       = vec[base+6][NC-1:0];
        errors_before = errors;
        gap           = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);

        err_seen = '0;
        joined   = '0;
        for (int c = 0; c < NC; c++) begin
            rel_cnt[c] = 0;
        end

        // A valid global barrier starts a wait unless the step expects an error for it
        for (int c = 0; c < NC; c++) begin
            cur            = gbar_instr_t'(vec[base+1+c][6:0]);
            instr[c]       = cur;
            instr_valid[c] = vmask[c];
            if (vmask[c] && cur.op == OP_GLOBAL && !exp_err[c]) begin
                joined[c] = 1'b1;
            end
        end
        @(negedge clk);
        sample_outputs();
        idle_inputs();

        // Serialized arrivals make the release latency vary
        wait_cycles = 1;
        rel_seen    = released_mask();
        while ((rel_seen & exp_rel) != exp_rel && wait_cycles < REL_TIMEOUT) begin
            @(negedge clk);
            sample_outputs();
            wait_cycles++;
            rel_seen = released_mask();
        end
        if ((rel_seen & exp_rel) != exp_rel) begin
            $display("Timeout at %0t: step %0d still waits for releases on cores %b",
                     $time, s, exp_rel & ~rel_seen);
            errors++;
        end

        // Late or duplicate pulses would show up in this window
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            sample_outputs();
        end

        for (int c = 0; c < NC; c++) begin
            check_value($sformatf("bar_release[%0d] pulses", c), 32'(rel_cnt[c]),
                        32'(exp_rel[c]));
        end
        check_value("err", 32'(err_seen), 32'(exp_err));
        waiting = (waiting | joined) & ~exp_rel;
        check_value("stall", 32'(stall), 32'(waiting));

        steps++;
        $display("Step %0d %s: valid %b err %b release %b stall %b",
                 s, (errors == errors_before) ? "ok" : "bad",
                 vmask, err_seen, rel_seen, stall);
    endtask

    initial begin
        int s;
        bit done;
        seed    = 13963;
        checks  = 0;
        errors  = 0;
        steps   = 0;
        waiting = '0;
        clk     = 1'b0;
        reset   = 1'b1;
        idle_inputs();
        $readmemh("verification/gbar_vectors.txt", vec);

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // Nothing may be pending straight out of reset
        check_value("stall", 32'(stall), 32'(0));
        check_value("err", 32'(err), 32'(0));
        check_value("bar_release", 32'(bar_release), 32'(0));

        s    = 0;
        done = 1'b0;
        while (!done) begin
            if (s >= MAX_STEPS) begin
                $display("Vector file has no end marker within %0d steps", MAX_STEPS);
                errors++;
                done = 1'b1;
            end else if (vec[s*VEC_WORDS] == 8'hff) begin
                done = 1'b1;
            end else begin
                run_step(s);
                s++;
            end
        end
        if (steps == 0) begin
            $display("Vector file holds no steps");
            errors++;
        end

        $display("Steps %0d, checks %0d, errors %0d", steps, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verification/gbar_vectors.txt
// Columns: valid mask, instr core0..core3, expected err mask, expected release mask
// Instr byte is {op[6:5], bar_id[4:3], count[2:0]}, op 1 global, 2 local. Line ff ends.
01 2b 00 00 00 00 00  // core 0 joins barrier 1 of 3
02 00 2b 00 00 00 00  // core 1 joins barrier 1 of 3
04 00 00 2b 00 00 07  // core 2 completes barrier 1
08 00 00 00 31 00 08  // count 1 on barrier 2 releases core 3 at once
08 00 00 00 31 00 08  // same id again behaves as fresh
03 22 3a 00 00 00 00  // barrier 0 and barrier 3 both open
04 00 00 3a 00 00 06  // barrier 3 completes with cores 1 and 2
08 00 00 00 22 00 09  // barrier 0 completes with cores 0 and 3
0f 20 25 27 42 07 00  // counts 0, 5 and 7 are errors, local is ignored
03 03 4c 00 00 00 00  // OP_NONE and OP_LOCAL produce nothing
0f 2a 2a 3a 3a 00 0f  // two barriers complete from one cycle of arrivals
01 34 00 00 00 00 00  // core 0 opens barrier 2 of 4
0e 00 34 34 34 00 0f  // three final arrivals in the same cycle
0f 34 34 34 34 00 0f  // all four cores arrive together
02 00 21 00 00 00 02  // count 1 on barrier 0
05 22 00 22 00 00 05  // barrier 0 reused right after
ff 00 00 00 00 00 00

// File: gbar_subsystem.f
+incdir+src
src/gbar_pkg.sv
src/gbar_decode.sv
src/gbar_req_arbiter.sv
src/gbar_unit.sv
src/gbar_release.sv
src/gbar_subsystem.sv
verification/gbar_subsystem_tb.sv

// File: Makefile
# Verilator build and run for the global barrier block
# Override any variable on the command line, for example make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= gbar_subsystem_tb
FILELIST  ?= gbar_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
